// File: rtl/key_schedule.sv
/* Key schedule
   128-bit key that rotates by a byte and folds in the address on every access */
`timescale 1ns/100ps

module key_schedule (
    input  logic              clk,
    input  logic              rst,
    mem_bus_if.target         bus,
    output trust_pkg::key_t   key
);

    // Any strobe counts as one access
    logic access;

    // Byte leaving the top of the key
    logic [7:0] top_byte;

    // Byte entering at the bottom
    logic [7:0] in_byte;

    // Key for the next access edge
    trust_pkg::key_t key_next;

    assign access = bus.write_enable | bus.read_enable;

    // Rotation with the address mixed into the wrapped byte
    always_comb begin
        top_byte = key[trust_pkg::KEY_W-1 -: 8];
        in_byte  = top_byte ^ bus.addr;
        key_next = {key[trust_pkg::KEY_W-9:0], in_byte};
    end

    // Key register
    // Idle cycles hold the value, so only the access sequence shapes it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= trust_pkg::KEY_INIT;
        end else if (access) begin
            key <= key_next;
        end
    end

endmodule

// File: rtl/mem_array.sv
/* Storage array
   256 words with payload-masked writes, registered reads and a one-cycle valid flag */
`timescale 1ns/100ps

module mem_array (
    input  logic              clk,
    input  logic              rst,
    mem_bus_if.target         bus,
    input  trust_pkg::load_t  load,
    output trust_pkg::data_t  read_data,
    output logic              valid
);

    // Word storage
    trust_pkg::data_t mem [trust_pkg::DEPTH];

    // Decoded operations, write has priority
    logic do_write;
    logic do_read;

    // Any strobe counts as one access
    logic access;

    // Payload bits that mask the stored word
    trust_pkg::data_t mask;

    // Word as it lands in the array
    trust_pkg::data_t masked_data;

    assign do_write = bus.write_enable;
    assign do_read  = bus.read_enable & ~bus.write_enable;
    assign access   = bus.write_enable | bus.read_enable;

    // Low payload bits only
    assign mask        = load[trust_pkg::DATA_W-1:0];
    assign masked_data = bus.write_data ^ mask;

    // Array write
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[bus.addr] <= masked_data;
        end
    end

    // Read register
    // Holds its last value across writes and idle cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_data <= '0;
        end else if (do_read) begin
            read_data <= mem[bus.addr];
        end
    end

    // Valid is high in the cycle after any access
    // Back-to-back accesses keep it high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= access;
        end
    end

endmodule

// File: rtl/mem_bus_if.sv
/* Memory bus
   Address, write data and the write and read strobes of one access */
`timescale 1ns/100ps

interface mem_bus_if;

    // Location of the access
    trust_pkg::addr_t addr;

    // Word to be stored on a write
    trust_pkg::data_t write_data;

    // Strobes, write wins when both are high
    logic write_enable;
    logic read_enable;

    // Driven from the top level ports
    modport host (
        output addr,
        output write_data,
        output write_enable,
        output read_enable
    );

    // Blocks that observe the access
    modport target (
        input addr,
        input write_data,
        input write_enable,
        input read_enable
    );

endinterface

// File: rtl/memory_host.sv
/* Memory host
   Single-port 256x16 memory with a key schedule and hidden payload on every write */
`timescale 1ns/100ps

module memory_host (
    input  logic              clk,
    input  logic              rst,
    input  trust_pkg::addr_t  addr,
    input  trust_pkg::data_t  write_data,
    input  logic              write_enable,
    input  logic              read_enable,
    output trust_pkg::data_t  read_data,
    output logic              valid
);

    // Internal bus shared by the three blocks
    mem_bus_if bus_i ();

    // Hidden state passed between blocks
    trust_pkg::key_t  key;
    trust_pkg::load_t load;

    // Host side of the bus, driven straight from the ports
    assign bus_i.addr         = addr;
    assign bus_i.write_data   = write_data;
    assign bus_i.write_enable = write_enable;
    assign bus_i.read_enable  = read_enable;

    // Key register, advanced by each access
    key_schedule key_schedule_i (
        .clk (clk),
        .rst (rst),
        .bus (bus_i.target),
        .key (key)
    );

    // Payload from key and LFSR
    payload_gen payload_gen_i (
        .clk  (clk),
        .rst  (rst),
        .bus  (bus_i.target),
        .key  (key),
        .load (load)
    );

    // Storage with masked writes
    mem_array mem_array_i (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus_i.target),
        .load      (load),
        .read_data (read_data),
        .valid     (valid)
    );

endmodule

// File: rtl/payload_gen.sv
/* Payload generator
   Access-stepped 20-bit LFSR combined with the two key halves into a 64-bit load */
`timescale 1ns/100ps

module payload_gen (
    input  logic              clk,
    input  logic              rst,
    mem_bus_if.target         bus,
    input  trust_pkg::key_t   key,
    output trust_pkg::load_t  load
);

    // Any strobe counts as one access
    logic access;

    // LFSR state and its next value
    trust_pkg::lfsr_t lfsr;
    trust_pkg::lfsr_t lfsr_next;

    // Feedback from the two taps
    logic feedback;

    // Key halves folded together
    trust_pkg::load_t key_fold;

    // LFSR widened to payload size
    trust_pkg::load_t lfsr_ext;

    assign access = bus.write_enable | bus.read_enable;

    // Fibonacci step, new bit shifted in at the bottom
    always_comb begin
        feedback  = lfsr[trust_pkg::LFSR_TAP_A] ^ lfsr[trust_pkg::LFSR_TAP_B];
        lfsr_next = {lfsr[trust_pkg::LFSR_W-2:0], feedback};
    end

    // LFSR register, steps once per access edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= trust_pkg::LFSR_INIT;
        end else if (access) begin
            lfsr <= lfsr_next;
        end
    end

    // Fold the key
    // Low half XOR high half
    always_comb begin
        key_fold = key[trust_pkg::LOAD_W-1:0]
                 ^ key[trust_pkg::KEY_W-1:trust_pkg::LOAD_W];
    end

    // Zero-extend the LFSR into the low bits
    always_comb begin
        lfsr_ext = {{(trust_pkg::LOAD_W - trust_pkg::LFSR_W){1'b0}}, lfsr};
    end

    // Payload follows the current key and LFSR with no register
    // The memory sees the value from before the edge that updates them
    assign load = key_fold ^ lfsr_ext;

endmodule

// File: rtl/trust_pkg.sv
/* Trust testbed package
   Widths, vector types, reset values and the LFSR feedback rule */
package trust_pkg;

    // Field widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 16;
    localparam int KEY_W  = 128;
    localparam int LOAD_W = 64;
    localparam int LFSR_W = 20;

    // Number of memory words
    localparam int DEPTH = 256;

    // Address and data seen on the memory bus
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Hidden state and payload
    typedef logic [KEY_W-1:0]  key_t;
    typedef logic [LOAD_W-1:0] load_t;
    typedef logic [LFSR_W-1:0] lfsr_t;

    // Key after reset, 64-bit pattern repeated twice
    localparam key_t KEY_INIT = 128'hFEDC_BA98_7654_3210_FEDC_BA98_7654_3210;

    // LFSR after reset, all ones so it never locks up
    localparam lfsr_t LFSR_INIT = {LFSR_W{1'b1}};

    // Fibonacci feedback taps
    localparam int LFSR_TAP_A = 19;
    localparam int LFSR_TAP_B = 16;

    // One LFSR step
    // Shift left, feedback from the two taps enters at bit 0
    function automatic lfsr_t lfsr_step(lfsr_t state);
        logic feedback;
        feedback = state[LFSR_TAP_A] ^ state[LFSR_TAP_B];
        return {state[LFSR_W-2:0], feedback};
    endfunction

    // One key step
    // Rotate left by a byte, the outgoing byte is mixed with the address
    function automatic key_t key_step(key_t key, addr_t addr);
        logic [7:0] top_byte;
        top_byte = key[KEY_W-1 -: 8];
        return {key[KEY_W-9:0], top_byte ^ addr};
    endfunction

endpackage

// File: tb.f
+incdir+testbench
rtl/trust_pkg.sv
rtl/mem_bus_if.sv
rtl/key_schedule.sv
rtl/payload_gen.sv
rtl/mem_array.sv
rtl/memory_host.sv
testbench/tb_memory_host.sv

// File: testbench/tb_model.svh
/* Memory host reference model
   Key, LFSR and shadow memory, advanced once per access */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Hidden state as it stands before the next access edge
trust_pkg::key_t  model_key;
trust_pkg::lfsr_t model_lfsr;
int               model_accesses;

// Stored words, already masked
trust_pkg::data_t shadow_mem [trust_pkg::DEPTH];

// Back to the state right after reset
function automatic void model_reset();
    model_key      = trust_pkg::KEY_INIT;
    model_lfsr     = trust_pkg::LFSR_INIT;
    model_accesses = 0;
endfunction

// Fibonacci step, XOR of the two taps enters at bit 0
function automatic trust_pkg::lfsr_t lfsr_advance(trust_pkg::lfsr_t state);
    logic fb;
    fb = state[trust_pkg::LFSR_TAP_A] ^ state[trust_pkg::LFSR_TAP_B];
    return {state[18:0], fb};
endfunction

// Shift left by a byte, old top byte XOR address comes in at the bottom
function automatic trust_pkg::key_t key_rotate(trust_pkg::key_t key, trust_pkg::addr_t a);
    logic [7:0] wrapped;
    wrapped = key[127:120] ^ a;
    return {key[119:0], wrapped};
endfunction

// Low payload bits from both key halves and the zero-extended LFSR
function automatic trust_pkg::data_t payload_mask();
    trust_pkg::load_t load;
    load = model_key[63:0] ^ model_key[127:64] ^ {44'd0, model_lfsr};
    return load[15:0];
endfunction

// One cycle of bus activity, write wins over read
function automatic void model_access(
    bit               we,
    bit               re,
    trust_pkg::addr_t a,
    trust_pkg::data_t d
);
    if (!(we || re)) begin
        return;
    end
    // Mask uses the state from before this edge's update
    if (we) begin
        shadow_mem[a] = d ^ payload_mask();
    end
    model_key  = key_rotate(model_key, a);
    model_lfsr = lfsr_advance(model_lfsr);
    model_accesses++;
endfunction

`endif

// File: testbench/tb_memory_host.sv
/* Memory host testbench
   Directed tests of masked writes, read-back, valid timing and hidden state */
`timescale 1ns/100ps

module tb_memory_host;

    // Longest idle gap between accesses in the random test
    localparam int MAX_GAP = 5;

    // Reset, then each test in order, then the final check
    localparam int PLANNED_CYCLES = 4 + 2 + 5 + 13 + 6
                                  + 16 * (MAX_GAP + 1) + 1
                                  + 2 * 64 + 1 + 1;
    localparam int WATCHDOG_NS = 20 * PLANNED_CYCLES * 2;

    logic             clk;
    logic             rst;
    trust_pkg::addr_t addr;
    trust_pkg::data_t write_data;
    logic             write_enable;
    logic             read_enable;
    trust_pkg::data_t read_data;
    logic             valid;

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;

    // Expected outputs for the cycle after the one just driven
    logic             exp_valid;
    trust_pkg::data_t exp_read_data;

    `include "tb_model.svh"

    memory_host dut_i (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .read_data    (read_data),
        .valid        (valid)
    );

    always #10 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // Outputs settle at the edge, so they are stable 2 ns later
    task automatic check_outputs();
        check_count += 2;
        assert (valid === exp_valid) else begin
            $display("mismatch at %0d ns: valid is %b, expected %b",
                     $time, valid, exp_valid);
            error_count++;
        end
        assert (read_data === exp_read_data) else begin
            $display("mismatch at %0d ns: read_data is %h, expected %h",
                     $time, read_data, exp_read_data);
            error_count++;
        end
    endtask

    // One clock cycle: check the previous cycle, then drive this one
    task automatic access_cycle(
        input logic             we,
        input logic             re,
        input trust_pkg::addr_t a,
        input trust_pkg::data_t d
    );
        @(posedge clk);
        #2;
        check_outputs();
        addr         = a;
        write_data   = d;
        write_enable = we;
        read_enable  = re;
        exp_valid    = we | re;
        // read_data only reloads on a pure read
        if (re && !we) begin
            exp_read_data = shadow_mem[a];
        end
        model_access(we, re, a, d);
    endtask

    task automatic write_word(input trust_pkg::addr_t a, input trust_pkg::data_t d);
        access_cycle(1'b1, 1'b0, a, d);
    endtask

    task automatic read_word(input trust_pkg::addr_t a);
        access_cycle(1'b0, 1'b1, a, '0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) access_cycle(1'b0, 1'b0, '0, '0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%-24s passed", name);
        end else begin
            $display("%-24s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic check_reset_state();
        int e;
        e = error_count;
        idle_cycles(2);
        report_test("reset state", e);
    endtask

    task automatic masked_write_readback();
        int e;
        e = error_count;
        write_word(8'h12, 16'hA5A5);
        read_word(8'h12);
        write_word(8'hF0, 16'h0000);
        read_word(8'hF0);
        idle_cycles(1);
        report_test("masked write and read", e);
    endtask

    task automatic valid_follows_activity();
        int e;
        e = error_count;
        for (int i = 0; i < 4; i++) begin
            write_word(8'h40 + i, 16'h1111 * (i + 1));
        end
        for (int i = 0; i < 4; i++) begin
            read_word(8'h40 + i);
        end
        idle_cycles(2);
        // A lone access gives a single valid cycle
        write_word(8'h50, 16'hBEEF);
        idle_cycles(2);
        report_test("valid follows activity", e);
    endtask

    task automatic write_priority();
        int e;
        e = error_count;
        write_word(8'h77, 16'h1234);
        access_cycle(1'b1, 1'b1, 8'h77, 16'hCAFE);
        read_word(8'h77);
        // Never written before, so only a write makes the read defined
        access_cycle(1'b1, 1'b1, 8'h78, 16'h5A5A);
        read_word(8'h78);
        idle_cycles(1);
        report_test("write priority", e);
    endtask

    task automatic idle_holds_state();
        int               e;
        trust_pkg::addr_t addrs [8];
        e = error_count;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed);
            write_word(addrs[i], $random(seed));
            idle_cycles({$random(seed)} % (MAX_GAP + 1));
        end
        for (int i = 0; i < 8; i++) begin
            read_word(addrs[i]);
            idle_cycles({$random(seed)} % (MAX_GAP + 1));
        end
        idle_cycles(1);
        report_test("idle holds state", e);
    endtask

    task automatic address_dependent_key();
        int               e;
        bit               used [trust_pkg::DEPTH];
        trust_pkg::addr_t addrs [64];
        trust_pkg::addr_t a;
        e = error_count;
        for (int i = 0; i < 64; i++) begin
            a = $random(seed);
            // Walk to the next free word so all addresses differ
            while (used[a]) begin
                a = a + 1;
            end
            used[a]  = 1'b1;
            addrs[i] = a;
            write_word(a, $random(seed));
        end
        for (int i = 0; i < 64; i++) begin
            read_word(addrs[i]);
        end
        idle_cycles(1);
        report_test("address dependent key", e);
    endtask

    initial begin
        seed          = 27548;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        clk           = 1'b0;
        rst           = 1'b1;
        addr          = '0;
        write_data    = '0;
        write_enable  = 1'b0;
        read_enable   = 1'b0;
        exp_valid     = 1'b0;
        exp_read_data = '0;
        model_reset();

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        check_reset_state();
        masked_write_readback();
        valid_follows_activity();
        write_priority();
        idle_holds_state();
        address_dependent_key();

        // Outputs of the last driven cycle
        @(posedge clk);
        #2;
        check_outputs();

        $display("%0d tests, %0d accesses, %0d checks, %0d errors",
                 test_count, model_accesses, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
